//--- source/apuPkg.sv
/* Shared types and lookup tables for the cut-down APU.
   Mix tables cover levels 0 to 15 only; noise is pre-scaled into tndMixTable */
`default_nettype none

package apuPkg;

  typedef logic [3:0]  chanSample_t;  // Per-channel output level
  typedef logic [15:0] mixSample_t;   // Mixed output sample

  // Register map, only the kept channels
  typedef enum logic [4:0] {
    pulseDuty       = 5'h00,
    pulseUnused     = 5'h01,
    pulsePeriodLow  = 5'h02,
    pulsePeriodHigh = 5'h03,
    noiseControl    = 5'h0C,
    noisePeriod     = 5'h0E,
    noiseLength     = 5'h0F,
    apuStatus       = 5'h15,
    frameControl    = 5'h17
  } apuReg_t;

  typedef enum logic {fourStep, fiveStep} frameMode_t;

  // Length counter loads, indexed by data bits 7:3
  localparam logic [7:0] lengthTable [32] = '{
    8'h0A, 8'hFE, 8'h14, 8'h02, 8'h28, 8'h04, 8'h50, 8'h06,
    8'hA0, 8'h08, 8'h3C, 8'h0A, 8'h0E, 8'h0C, 8'h1A, 8'h0E,
    8'h0C, 8'h10, 8'h18, 8'h12, 8'h30, 8'h14, 8'h60, 8'h16,
    8'hC0, 8'h18, 8'h48, 8'h1A, 8'h10, 8'h1C, 8'h20, 8'h1E
  };

  localparam logic [11:0] noisePeriodTable [16] = '{
    12'h004, 12'h008, 12'h010, 12'h020, 12'h040, 12'h060, 12'h080, 12'h0A0,
    12'h0CA, 12'h0FE, 12'h17C, 12'h1FC, 12'h2FA, 12'h3F8, 12'h7F2, 12'hFE4
  };

  localparam logic [15:0] pulseMixTable [16] = '{
    16'd0,    16'd760,  16'd1503, 16'd2228, 16'd2936, 16'd3627, 16'd4303, 16'd4963,
    16'd5609, 16'd6240, 16'd6858, 16'd7462, 16'd8053, 16'd8631, 16'd9198, 16'd9752
  };

  // Second curve sampled at twice the noise level
  localparam logic [15:0] tndMixTable [16] = '{
    16'd0,    16'd874,  16'd1735, 16'd2581, 16'd3414, 16'd4234,  16'd5041,  16'd5836,
    16'd6618, 16'd7389, 16'd8147, 16'd8895, 16'd9631, 16'd10356, 16'd11070, 16'd11774
  };

endpackage

`default_nettype wire

//--- source/chanBus.sv
/* Register writes and frame clocks from the controller to one channel.
   All strobes are single-cycle and carry no handshake */
`default_nettype none
`timescale 1ns/1ps

interface chanBus;

  logic       regWrite;    // Write strobe for this channel
  logic [1:0] regIndex;    // Register within the channel
  logic [7:0] regData;
  logic [7:0] lengthLoad;  // Table value for regData[7:3]
  logic       quarterClk;
  logic       halfClk;
  logic       enabled;     // Channel enable level

  modport ctrl (
    output regWrite, regIndex, regData, lengthLoad,
    output quarterClk, halfClk, enabled
  );

  modport chan (
    input regWrite, regIndex, regData, lengthLoad,
    input quarterClk, halfClk, enabled
  );

endinterface

`default_nettype wire

//--- source/apuControl.sv
/* Frame steps are equally spaced by FrameStep cycles. Enable bits are din[0] for
   pulse and din[3] for noise; status bit 6 is the raw frame interrupt flag */
`default_nettype none
`timescale 1ns/1ps

module apuControl import apuPkg::*; #(
  parameter int FrameStep = 7457
) (
  input  logic        clk,
  input  logic        reset,
  input  apuReg_t     addr,
  input  logic [7:0]  din,
  input  logic        write,
  input  logic        read,
  input  logic        pulseActive,
  input  logic        noiseActive,
  output logic [7:0]  dout,
  output logic        irq,
  chanBus.ctrl        pulseBus,
  chanBus.ctrl        noiseBus
);

  localparam int CountWidth = $clog2(5 * FrameStep + 1);
  localparam logic [CountWidth-1:0] Step1 = CountWidth'(FrameStep);
  localparam logic [CountWidth-1:0] Step2 = CountWidth'(2 * FrameStep);
  localparam logic [CountWidth-1:0] Step3 = CountWidth'(3 * FrameStep);
  localparam logic [CountWidth-1:0] Step4 = CountWidth'(4 * FrameStep);
  localparam logic [CountWidth-1:0] Step5 = CountWidth'(5 * FrameStep);

  logic [4:0]            addrBits;
  logic [7:0]            lengthLoad;
  logic                  statusWrite, statusRead, frameWrite;
  logic                  pulseEnable, noiseEnable;
  logic                  irqInhibit, frameIrq, pendingClk;
  logic                  quarterClk, halfClk;
  frameMode_t            frameMode;
  logic [CountWidth-1:0] frameCount, lastCount;

  // ----------------------------------------------------------------------
  // Address decode and channel buses
  assign addrBits    = addr;
  assign statusWrite = write && addr == apuStatus;
  assign statusRead  = read && addr == apuStatus;
  assign frameWrite  = write && addr == frameControl;
  assign lengthLoad  = lengthTable[din[7:3]];

  assign pulseBus.regWrite   = write && addrBits[4:2] == 3'd0;  // 0x00..0x03
  assign noiseBus.regWrite   = write && addrBits[4:2] == 3'd3;  // 0x0C..0x0F
  assign pulseBus.regIndex   = addrBits[1:0];
  assign noiseBus.regIndex   = addrBits[1:0];
  assign pulseBus.regData    = din;
  assign noiseBus.regData    = din;
  assign pulseBus.lengthLoad = lengthLoad;
  assign noiseBus.lengthLoad = lengthLoad;
  assign pulseBus.enabled    = pulseEnable;
  assign noiseBus.enabled    = noiseEnable;
  assign pulseBus.quarterClk = quarterClk;
  assign noiseBus.quarterClk = quarterClk;
  assign pulseBus.halfClk    = halfClk;
  assign noiseBus.halfClk    = halfClk;

  // ----------------------------------------------------------------------
  // Frame sequencer
  assign lastCount  = (frameMode == fiveStep) ? Step5 : Step4;
  assign quarterClk = pendingClk || frameCount == Step1 || frameCount == Step2 ||
                      frameCount == Step3 || frameCount == Step4;
  assign halfClk    = pendingClk || frameCount == Step2 || frameCount == Step4;

  always_ff @(posedge clk) begin
    if (reset) begin
      frameMode   <= fourStep;
      irqInhibit  <= 1'b0;
      frameIrq    <= 1'b0;
      pendingClk  <= 1'b0;
      pulseEnable <= 1'b0;
      noiseEnable <= 1'b0;
      frameCount  <= '0;
    end else begin
      pendingClk <= frameWrite && din[7];  // Five-step write clocks at once
      if (frameWrite) begin
        frameMode  <= din[7] ? fiveStep : fourStep;
        irqInhibit <= din[6];
        frameCount <= '0;
      end else if (frameCount == lastCount) begin
        frameCount <= '0;
      end else begin
        frameCount <= frameCount + 1'b1;
      end
      if (statusWrite) begin
        pulseEnable <= din[0];
        noiseEnable <= din[3];
      end
      // Set wins over a clear on the same cycle
      if (frameMode == fourStep && frameCount == Step4 && !irqInhibit)
        frameIrq <= 1'b1;
      else if (statusRead || (frameWrite && din[6]))
        frameIrq <= 1'b0;
    end
  end

  assign irq  = frameIrq;
  assign dout = read ? {1'b0, frameIrq, 4'b0000, noiseActive, pulseActive} : 8'h00;

  halfNeedsQuarter: assert property (@(posedge clk) disable iff (reset)
    pulseBus.halfClk |-> noiseBus.quarterClk);

endmodule

`default_nettype wire

//--- source/envelopeUnit.sv
/* Volume envelope clocked by quarter-frame pulses.
   A restart is only served at the next quarter clock */
`default_nettype none
`timescale 1ns/1ps

module envelopeUnit import apuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        quarterClk,
  input  logic        restart,
  input  logic        loopFlag,
  input  logic        constantFlag,
  input  chanSample_t volume,
  output chanSample_t level
);

  chanSample_t divider;
  chanSample_t decayLevel;
  logic        restartPending;

  always_ff @(posedge clk) begin
    if (reset) begin
      divider        <= '0;
      decayLevel     <= '0;
      restartPending <= 1'b0;
    end else begin
      if (restart)
        restartPending <= 1'b1;  // Keep a late restart for the next clock
      else if (quarterClk)
        restartPending <= 1'b0;
      if (quarterClk) begin
        if (restartPending) begin
          divider    <= volume;
          decayLevel <= 4'd15;
        end else if (divider == '0) begin
          divider <= volume;
          if (decayLevel != '0)
            decayLevel <= decayLevel - 4'd1;
          else if (loopFlag)
            decayLevel <= 4'd15;  // Wrap when looping
        end else begin
          divider <= divider - 4'd1;
        end
      end
    end
  end

  assign level = constantFlag ? volume : decayLevel;

endmodule

`default_nettype wire

//--- source/pulseChannel.sv
/* Pulse channel without sweep unit; a period below 8 mutes the output.
   The loop flag doubles as the length counter halt */
`default_nettype none
`timescale 1ns/1ps

module pulseChannel import apuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  chanBus.chan        bus,
  output chanSample_t level,
  output logic        lengthActive
);

  logic [1:0]  duty;
  logic        loopFlag, constantFlag;
  chanSample_t volume, envLevel;
  logic [10:0] period;
  logic [11:0] timer;
  logic [2:0]  seqPos;
  logic [7:0]  lengthCount;
  logic        lengthWrite, dutyHigh;

  assign lengthWrite = bus.regWrite && bus.regIndex == 2'd3;

  envelopeUnit envelope (
    .clk          (clk),
    .reset        (reset),
    .quarterClk   (bus.quarterClk),
    .restart      (lengthWrite),
    .loopFlag     (loopFlag),
    .constantFlag (constantFlag),
    .volume       (volume),
    .level        (envLevel)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      duty         <= '0;
      loopFlag     <= 1'b0;
      constantFlag <= 1'b0;
      volume       <= '0;
      period       <= '0;
      timer        <= '0;
      seqPos       <= '0;
      lengthCount  <= '0;
    end else begin
      // Timer runs 2*period+1 cycles per sequence step
      if (timer == '0) begin
        timer  <= {period, 1'b0};
        seqPos <= seqPos - 3'd1;
      end else begin
        timer <= timer - 12'd1;
      end
      if (bus.regWrite) begin
        case (bus.regIndex)
          2'd0: begin
            duty         <= bus.regData[7:6];
            loopFlag     <= bus.regData[5];
            constantFlag <= bus.regData[4];
            volume       <= bus.regData[3:0];
          end
          2'd2: period[7:0] <= bus.regData;
          2'd3: begin
            period[10:8] <= bus.regData[2:0];
            seqPos       <= '0;  // Write wins over a timer step
          end
          default: ;
        endcase
      end
      if (!bus.enabled)
        lengthCount <= '0;
      else if (lengthWrite)
        lengthCount <= bus.lengthLoad;
      else if (bus.halfClk && lengthCount != '0 && !loopFlag)
        lengthCount <= lengthCount - 8'd1;
    end
  end

  always_comb begin
    case (duty)
      2'd0:    dutyHigh = seqPos == 3'd7;
      2'd1:    dutyHigh = seqPos >= 3'd6;
      2'd2:    dutyHigh = seqPos >= 3'd4;
      default: dutyHigh = seqPos < 3'd6;  // Inverted 25%
    endcase
  end

  assign lengthActive = lengthCount != '0;
  assign level = (lengthActive && period[10:3] != '0 && dutyHigh) ? envLevel : '0;

  silentWhenExpired: assert property (@(posedge clk) disable iff (reset)
    lengthCount == '0 |-> level == '0);

endmodule

`default_nettype wire

//--- source/noiseChannel.sv
/* Noise channel with a 15-bit shift-register generator seeded to 1.
   regIndex 0, 2 and 3 map to registers 0x0C, 0x0E and 0x0F */
`default_nettype none
`timescale 1ns/1ps

module noiseChannel import apuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  chanBus.chan        bus,
  output chanSample_t level,
  output logic        lengthActive
);

  logic        loopFlag, constantFlag, shortMode;
  chanSample_t volume, envLevel;
  logic [3:0]  periodIndex;
  logic [11:0] timer;
  logic [14:0] lfsr;
  logic [7:0]  lengthCount;
  logic        lengthWrite, feedback;

  assign lengthWrite = bus.regWrite && bus.regIndex == 2'd3;
  assign feedback    = lfsr[0] ^ (shortMode ? lfsr[6] : lfsr[1]);

  envelopeUnit envelope (
    .clk          (clk),
    .reset        (reset),
    .quarterClk   (bus.quarterClk),
    .restart      (lengthWrite),
    .loopFlag     (loopFlag),
    .constantFlag (constantFlag),
    .volume       (volume),
    .level        (envLevel)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      loopFlag     <= 1'b0;
      constantFlag <= 1'b0;
      shortMode    <= 1'b0;
      volume       <= '0;
      periodIndex  <= '0;
      timer        <= '0;
      lfsr         <= 15'd1;
      lengthCount  <= '0;
    end else begin
      if (timer == '0) begin
        timer <= noisePeriodTable[periodIndex];
        lfsr  <= {feedback, lfsr[14:1]};  // Shift once per reload
      end else begin
        timer <= timer - 12'd1;
      end
      if (bus.regWrite && bus.regIndex == 2'd0) begin
        loopFlag     <= bus.regData[5];
        constantFlag <= bus.regData[4];
        volume       <= bus.regData[3:0];
      end
      if (bus.regWrite && bus.regIndex == 2'd2) begin
        shortMode   <= bus.regData[7];
        periodIndex <= bus.regData[3:0];
      end
      if (!bus.enabled)
        lengthCount <= '0;
      else if (lengthWrite)
        lengthCount <= bus.lengthLoad;
      else if (bus.halfClk && lengthCount != '0 && !loopFlag)
        lengthCount <= lengthCount - 8'd1;
    end
  end

  assign lengthActive = lengthCount != '0;
  assign level = (lengthActive && !lfsr[0]) ? envLevel : '0;

  generatorAlive: assert property (@(posedge clk) disable iff (reset) lfsr != '0);

endmodule

`default_nettype wire

//--- source/apuMixer.sv
/* Nonlinear two-curve mix of the pulse and noise levels.
   The output is registered and lags the channel levels by one cycle */
`default_nettype none
`timescale 1ns/1ps

module apuMixer import apuPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  chanSample_t pulseLevel,
  input  chanSample_t noiseLevel,
  output mixSample_t  sample
);

  mixSample_t mixSum;

  // Largest sum is 9752 + 11774, no overflow
  assign mixSum = pulseMixTable[pulseLevel] + tndMixTable[noiseLevel];

  always_ff @(posedge clk) begin
    if (reset)
      sample <= '0;
    else
      sample <= mixSum;
  end

endmodule

`default_nettype wire

//--- source/apuCore.sv
/* Top level of the cut-down APU with one pulse and one noise channel.
   Every clk is one APU cycle; FrameStep sets the frame step spacing */
`default_nettype none
`timescale 1ns/1ps

module apuCore import apuPkg::*; #(
  parameter int FrameStep = 7457
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [4:0] addr,
  input  logic [7:0] din,
  input  logic       write,
  input  logic       read,
  output logic [7:0] dout,
  output mixSample_t sample,
  output logic       irq
);

  chanBus pulseBus ();
  chanBus noiseBus ();

  chanSample_t pulseLevel, noiseLevel;
  logic        pulseActive, noiseActive;

  apuControl #(.FrameStep(FrameStep)) control (
    .clk         (clk),
    .reset       (reset),
    .addr        (apuReg_t'(addr)),
    .din         (din),
    .write       (write),
    .read        (read),
    .pulseActive (pulseActive),
    .noiseActive (noiseActive),
    .dout        (dout),
    .irq         (irq),
    .pulseBus    (pulseBus.ctrl),
    .noiseBus    (noiseBus.ctrl)
  );

  pulseChannel pulse (.clk(clk), .reset(reset), .bus(pulseBus.chan),
                      .level(pulseLevel), .lengthActive(pulseActive));

  noiseChannel noise (.clk(clk), .reset(reset), .bus(noiseBus.chan),
                      .level(noiseLevel), .lengthActive(noiseActive));

  apuMixer mixer (.clk(clk), .reset(reset), .pulseLevel(pulseLevel),
                  .noiseLevel(noiseLevel), .sample(sample));

endmodule

`default_nettype wire

//--- bench/apuCoreTb.sv
/* Drives apuCore with FrameStep 64 so frames stay short.
   Inputs change 1 ns after a rising edge; dout and sample are read mid-cycle */
`default_nettype none
`timescale 1ns/1ps

module apuCoreTb import apuPkg::*; ();

  localparam int FrameStep  = 64;
  localparam int ClkPeriod  = 4;
  localparam int TestFrames = 20;  // Summed test length, in frames
  localparam int WatchdogNs = TestFrames * 5 * FrameStep * ClkPeriod * 3 / 2;

  logic        clk, reset, write, read, irq;
  logic [4:0]  addr;
  logic [7:0]  din, dout;
  mixSample_t  sample;

  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleNum = 0;
  int          lastWriteCycle = 0;
  int          mixMode = 0;  // 0 idle, 1 pulse free, 2 pulse muted
  chanSample_t pulseVol, noiseVol;
  logic        pulseOn, pulseOff, pulseOnSeen, pulseOffSeen;

  apuCore #(.FrameStep(FrameStep)) apuCore_inst (
    .clk(clk), .reset(reset), .addr(addr), .din(din), .write(write),
    .read(read), .dout(dout), .sample(sample), .irq(irq)
  );

  // ----------------------------------------------------------------------
  // Reference model
  function automatic int mixRef(chanSample_t pulseLevel, chanSample_t noiseLevel);
    return int'(pulseMixTable[pulseLevel]) + int'(tndMixTable[noiseLevel]);
  endfunction

  // Frame spans counts 0 to 4*FrameStep, half clocks at 2* and 4*
  function automatic int halfClkOffset(int n);
    int pos;
    pos = (n % 2 == 1) ? 2 * FrameStep : 4 * FrameStep;
    return pos + (4 * FrameStep + 1) * ((n - 1) / 2);
  endfunction

  function automatic int lengthAfter(int load, int halves);
    return (load > halves) ? load - halves : 0;
  endfunction

  // ----------------------------------------------------------------------
  // Bus tasks and checker
  task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic idleCycle();
    @(posedge clk);
    #1;
    write = 1'b0;
    read  = 1'b0;
  endtask

  task automatic writeReg(logic [4:0] a, logic [7:0] d);
    @(posedge clk);
    #1;
    addr = a;
    din = d;
    write = 1'b1;
    lastWriteCycle = cycleNum;
    @(posedge clk);
    #1;
    write = 1'b0;
  endtask

  task automatic readStatus(output logic [7:0] value);
    @(posedge clk);
    #1;
    addr = 5'h15;
    read = 1'b1;
    #1 value = dout;  // Combinational, stable mid-cycle
    @(posedge clk);
    #1;
    read = 1'b0;
  endtask

  task automatic waitUntilCycle(int target);
    while (cycleNum < target - 1)
      idleCycle();
  endtask

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) cycleNum <= cycleNum + 1;

  // Sample lags the levels by one cycle, so modes start after settling
  always @(negedge clk) begin
    pulseOn  = int'(sample) == mixRef(pulseVol, 0) || int'(sample) == mixRef(pulseVol, noiseVol);
    pulseOff = int'(sample) == mixRef(0, 0) || int'(sample) == mixRef(0, noiseVol);
    if (mixMode == 1) begin
      if (pulseOn) pulseOnSeen = 1'b1;
      if (pulseOff) pulseOffSeen = 1'b1;
      checkValue("sample in mix set", 32'(pulseOn || pulseOff), 1);
    end else if (mixMode == 2) begin
      checkValue("sample with pulse muted", 32'(pulseOff), 1);
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog timeout: tests did not finish within %0d ns", WatchdogNs);
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    logic [7:0] status;
    logic [4:0] lenIdx;
    logic [1:0] duty;
    logic       irqSeen;
    int         lenLoad, frameStart, target, riseCycle;

    reset = 1'b1;
    write = 1'b0;
    read = 1'b0;
    addr = '0;
    din = '0;
    pulseVol = '0;
    noiseVol = '0;
    void'($urandom(32'hd079));
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;

    // After reset
    checkValue("irq", 32'(irq), 0);
    checkValue("dout", 32'(dout), 0);
    checkValue("sample", 32'(sample), 0);
    readStatus(status);
    checkValue("status", 32'(status), 0);

    // Length load and enable
    writeReg(5'h15, 8'h09);
    writeReg(5'h03, {5'($urandom_range(31, 0)), 3'b000});
    writeReg(5'h0F, {5'($urandom_range(31, 0)), 3'b000});
    readStatus(status);
    checkValue("dout[1:0] enabled", 32'(status[1:0]), 3);
    writeReg(5'h15, 8'h00);
    readStatus(status);
    checkValue("dout[1:0] disabled", 32'(status[1:0]), 0);

    // Length countdown, frame restarted with interrupt inhibited
    writeReg(5'h15, 8'h01);
    writeReg(5'h00, 8'h10);  // Constant volume, length not halted
    writeReg(5'h17, 8'h40);
    frameStart = lastWriteCycle;
    lenIdx = 5'(2 * $urandom_range(3, 0) + 3);  // Short loads 2 to 8
    lenLoad = int'(lengthTable[lenIdx]);
    writeReg(5'h03, {lenIdx, 3'b000});
    target = frameStart + 1 + halfClkOffset(lenLoad);
    waitUntilCycle(target);
    readStatus(status);
    checkValue("dout[0] last half clock", 32'(status[0]),
               32'(lengthAfter(lenLoad, lenLoad - 1) != 0));
    readStatus(status);
    checkValue("dout[0] expired", 32'(status[0]), 32'(lengthAfter(lenLoad, lenLoad) != 0));

    // Frame interrupt
    readStatus(status);
    checkValue("dout[6] while inhibited", 32'(status[6]), 0);
    writeReg(5'h17, 8'h00);
    frameStart = lastWriteCycle;
    riseCycle = -1;
    for (int i = 0; i < 5 * FrameStep && riseCycle < 0; i++) begin
      idleCycle();
      if (irq) riseCycle = cycleNum;
    end
    if (riseCycle < 0) begin
      errorCount++;
      $display("irq did not rise within a frame after the frame control write");
    end else begin
      checkValue("irq rise cycle", 32'(riseCycle), 32'(frameStart + 4 * FrameStep + 2));
    end
    readStatus(status);
    checkValue("dout[6]", 32'(status[6]), 1);
    checkValue("irq after read", 32'(irq), 0);
    irqSeen = 1'b0;
    writeReg(5'h17, 8'h40);
    repeat (3 * (4 * FrameStep + 1)) begin
      idleCycle();
      if (irq) irqSeen = 1'b1;
    end
    checkValue("irq inhibited", 32'(irqSeen), 0);
    writeReg(5'h17, 8'h80);
    repeat (3 * (5 * FrameStep + 1)) begin
      idleCycle();
      if (irq) irqSeen = 1'b1;
    end
    checkValue("irq in fiveStep", 32'(irqSeen), 0);

    // Mixing
    pulseVol = 4'($urandom_range(15, 1));
    noiseVol = 4'($urandom_range(15, 1));
    duty = 2'($urandom_range(3, 0));
    writeReg(5'h15, 8'h09);
    writeReg(5'h00, {duty, 2'b11, pulseVol});  // Length halted, constant volume
    writeReg(5'h02, 8'($urandom_range(23, 8)));
    writeReg(5'h03, 8'h08);
    writeReg(5'h0C, {4'b0011, noiseVol});
    writeReg(5'h0E, 8'($urandom_range(3, 0)));
    writeReg(5'h0F, 8'h08);
    repeat (2) idleCycle();
    pulseOnSeen = 1'b0;
    pulseOffSeen = 1'b0;
    mixMode = 1;
    repeat (800) idleCycle();
    mixMode = 0;
    checkValue("pulseOnSeen", 32'(pulseOnSeen), 1);
    checkValue("pulseOffSeen", 32'(pulseOffSeen), 1);
    writeReg(5'h02, 8'($urandom_range(7, 0)));  // Period below 8 mutes
    repeat (2) idleCycle();
    mixMode = 2;
    repeat (300) idleCycle();
    mixMode = 0;

    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- apuCore.f
source/apuPkg.sv
source/chanBus.sv
source/apuControl.sv
source/envelopeUnit.sv
source/pulseChannel.sv
source/noiseChannel.sv
source/apuMixer.sv
source/apuCore.sv
bench/apuCoreTb.sv

//--- Makefile
TOP := apuCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f apuCore.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f apuCore.f -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
